// ==== all.f ====
hw/mem_pkg.sv
hw/mem_req_stage.sv
hw/axi_lite_master.sv
hw/load_format_stage.sv
hw/axi_lite_ram.sv
hw/mem_sys_top.sv
verif/mem_sys_checker.sv
verif/mem_sys_tb.sv

// ==== hw/axi_lite_master.sv ====
`timescale 1ns/10ps
// AXI4-Lite master, one transaction open at a time
// misaligned requests never reach the bus and come back as errors
module axi_lite_master (
    input  logic                       clk,
    input  logic                       nrst,
    input  logic                       req_valid,
    output logic                       req_ready,
    input  mem_pkg::req_src_e          req_src,
    input  logic                       req_write,
    input  mem_pkg::mem_op_e           req_op,
    input  logic [mem_pkg::ADDR_W-1:0] req_addr,
    input  logic [3:0]                 req_wstrb,
    input  logic [mem_pkg::DATA_W-1:0] req_wdata,
    input  logic                       req_misaligned,
    output logic                       rsp_valid,
    output mem_pkg::req_src_e          rsp_src,
    output mem_pkg::mem_op_e           rsp_op,
    output logic [1:0]                 rsp_addr_lo,
    output logic [mem_pkg::DATA_W-1:0] rsp_rdata,
    output logic                       rsp_err,
    output logic [mem_pkg::ADDR_W-1:0] awaddr,
    output logic                       awvalid,
    input  logic                       awready,
    output logic [mem_pkg::DATA_W-1:0] wdata,
    output logic [3:0]                 wstrb,
    output logic                       wvalid,
    input  logic                       wready,
    input  logic [1:0]                 bresp,
    input  logic                       bvalid,
    output logic                       bready,
    output logic [mem_pkg::ADDR_W-1:0] araddr,
    output logic                       arvalid,
    input  logic                       arready,
    input  logic [mem_pkg::DATA_W-1:0] rdata,
    input  logic [1:0]                 rresp,
    input  logic                       rvalid,
    output logic                       rready
);
    import mem_pkg::*;

    axi_state_e        state;
    logic [ADDR_W-1:0] addr_q;
    logic              write_q;
    logic              addr_busy;
    logic              b_take;
    logic              r_take;

    assign req_ready = (state == st_idle);
    assign awaddr    = addr_q;
    assign araddr    = addr_q;
    assign bready    = (state == st_resp) && write_q;
    assign rready    = (state == st_resp) && !write_q;
    assign b_take    = bvalid && bready;
    assign r_take    = rvalid && rready;
    // some address or data beat still waiting for its ready
    assign addr_busy = (awvalid && !awready) || (wvalid && !wready) || (arvalid && !arready);

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state     <= st_idle;
            awvalid   <= 1'b0;
            wvalid    <= 1'b0;
            arvalid   <= 1'b0;
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= 1'b0;
            case (state)
                st_idle: begin
                    if (req_valid && req_misaligned) begin
                        rsp_valid <= 1'b1;             // fault without bus traffic
                    end else if (req_valid) begin
                        state   <= st_addr;
                        awvalid <= req_write;
                        wvalid  <= req_write;
                        arvalid <= !req_write;
                    end
                end
                st_addr: begin
                    if (awready) awvalid <= 1'b0;
                    if (wready)  wvalid  <= 1'b0;
                    if (arready) arvalid <= 1'b0;
                    if (!addr_busy) begin
                        state <= st_resp;
                    end
                end
                st_resp: begin
                    if (b_take || r_take) begin
                        rsp_valid <= 1'b1;
                        state     <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            addr_q      <= {req_addr[ADDR_W-1:2], 2'b00};  // word aligned on the bus
            write_q     <= req_write;
            wdata       <= req_wdata;
            wstrb       <= req_wstrb;
            rsp_src     <= req_src;
            rsp_op      <= req_op;
            rsp_addr_lo <= req_addr[1:0];
            rsp_rdata   <= '0;
            rsp_err     <= req_misaligned;
        end else if (b_take) begin
            rsp_err <= (bresp != RESP_OKAY);
        end else if (r_take) begin
            rsp_rdata <= rdata;
            rsp_err   <= (rresp != RESP_OKAY);
        end
    end

    assert property (@(posedge clk) disable iff (!nrst) awvalid && !awready |=> awvalid);
    assert property (@(posedge clk) disable iff (!nrst) wvalid && !wready |=> wvalid);
    assert property (@(posedge clk) disable iff (!nrst) arvalid && !arready |=> arvalid);

    // slave answers only the one transaction we opened
    assert property (@(posedge clk) disable iff (!nrst)
        (bvalid || rvalid) |-> state == st_resp && !(awvalid || wvalid || arvalid))
        else $error("response outside an open transaction");

endmodule

// ==== hw/axi_lite_ram.sv ====
`timescale 1ns/10ps
// AXI4-Lite RAM slave at address 0, takes AW and W only together
// out of range gives SLVERR, reads zero and leaves memory alone
module axi_lite_ram (
    input  logic                       clk,
    input  logic                       nrst,
    input  logic [mem_pkg::ADDR_W-1:0] awaddr,
    input  logic                       awvalid,
    output logic                       awready,
    input  logic [mem_pkg::DATA_W-1:0] wdata,
    input  logic [3:0]                 wstrb,
    input  logic                       wvalid,
    output logic                       wready,
    output logic [1:0]                 bresp,
    output logic                       bvalid,
    input  logic                       bready,
    input  logic [mem_pkg::ADDR_W-1:0] araddr,
    input  logic                       arvalid,
    output logic                       arready,
    output logic [mem_pkg::DATA_W-1:0] rdata,
    output logic [1:0]                 rresp,
    output logic                       rvalid,
    input  logic                       rready
);
    import mem_pkg::*;

    logic [DATA_W-1:0] mem [RAM_BYTES/4];
    logic              wr_take;
    logic              rd_take;
    logic              wr_in;
    logic              rd_in;
    logic [RAM_AW-1:0] wr_idx;
    logic [RAM_AW-1:0] rd_idx;

    assign awready = awvalid && wvalid && !bvalid;     // both beats at once
    assign wready  = awready;
    assign arready = arvalid && !rvalid;
    assign wr_take = awvalid && awready;
    assign rd_take = arvalid && arready;
    assign wr_in   = (awaddr < RAM_BYTES);
    assign rd_in   = (araddr < RAM_BYTES);
    assign wr_idx  = awaddr[RAM_AW+1:2];
    assign rd_idx  = araddr[RAM_AW+1:2];

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            bvalid <= 1'b0;
            bresp  <= RESP_OKAY;
            rvalid <= 1'b0;
            rresp  <= RESP_OKAY;
        end else begin
            if (wr_take) begin
                bvalid <= 1'b1;
                bresp  <= wr_in ? RESP_OKAY : RESP_SLVERR;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            if (rd_take) begin
                rvalid <= 1'b1;
                rresp  <= rd_in ? RESP_OKAY : RESP_SLVERR;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (wr_take && wr_in && wstrb[i]) begin
                mem[wr_idx][8*i +: 8] <= wdata[8*i +: 8];  // strobed lanes only
            end
        end
        if (rd_take) begin
            rdata <= rd_in ? mem[rd_idx] : '0;
        end
    end

endmodule

// ==== hw/load_format_stage.sv ====
`timescale 1ns/10ps
// load format, one register stage, never stalls
// pulses follow rsp_valid by exactly one cycle
module load_format_stage (
    input  logic                       clk,
    input  logic                       nrst,
    input  logic                       rsp_valid,
    input  mem_pkg::req_src_e          rsp_src,
    input  mem_pkg::mem_op_e           rsp_op,
    input  logic [1:0]                 rsp_addr_lo,
    input  logic [mem_pkg::DATA_W-1:0] rsp_rdata,
    input  logic                       rsp_err,
    output logic                       load_valid,
    output logic [mem_pkg::DATA_W-1:0] load_data,
    output logic                       store_done,
    output logic                       inst_valid,
    output logic [mem_pkg::DATA_W-1:0] inst_data,
    output logic                       mem_err
);
    import mem_pkg::*;

    logic [7:0]        byte_sel;
    logic [15:0]       half_sel;
    logic [DATA_W-1:0] load_val;
    logic              is_data;

    assign byte_sel = rsp_rdata[{rsp_addr_lo, 3'b000} +: 8];
    assign half_sel = rsp_rdata[{rsp_addr_lo[1], 4'b0000} +: 16];
    assign is_data  = (rsp_src == src_data);

    always_comb begin
        case (rsp_op)
            op_lb:   load_val = {{(DATA_W-8){byte_sel[7]}}, byte_sel};
            op_lh:   load_val = {{(DATA_W-16){half_sel[15]}}, half_sel};
            op_lbu:  load_val = {{(DATA_W-8){1'b0}}, byte_sel};
            op_lhu:  load_val = {{(DATA_W-16){1'b0}}, half_sel};
            default: load_val = rsp_rdata;             // lw, word as is
        endcase
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            load_valid <= 1'b0;
            store_done <= 1'b0;
            inst_valid <= 1'b0;
            mem_err    <= 1'b0;
        end else begin
            load_valid <= rsp_valid && is_data && !rsp_op[3];
            store_done <= rsp_valid && is_data && rsp_op[3];
            inst_valid <= rsp_valid && !is_data;
            mem_err    <= rsp_valid && rsp_err;
        end
    end

    always_ff @(posedge clk) begin
        if (rsp_valid) begin
            load_data <= load_val;
            inst_data <= rsp_rdata;                    // fetch passes whole
        end
    end

endmodule

// ==== hw/mem_pkg.sv ====
// shared types and sizes for the memory access unit
// RAM region starts at address 0, anything at or above RAM_BYTES faults
package mem_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int unsigned RAM_BYTES = 2048;
    localparam int RAM_AW = 9;                   // word index bits, RAM_BYTES/4 words

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // funct3 in the low bits, bit 3 marks a store
    typedef enum logic [3:0] {
        op_lb  = 4'b0000,
        op_lh  = 4'b0001,
        op_lw  = 4'b0010,
        op_lbu = 4'b0100,
        op_lhu = 4'b0101,
        op_sb  = 4'b1000,
        op_sh  = 4'b1001,
        op_sw  = 4'b1010
    } mem_op_e;

    typedef enum logic {
        src_data  = 1'b0,
        src_fetch = 1'b1
    } req_src_e;

    typedef enum logic [1:0] {
        st_idle = 2'b00,
        st_addr = 2'b01,
        st_resp = 2'b10
    } axi_state_e;

endpackage

// ==== hw/mem_req_stage.sv ====
`timescale 1ns/10ps
// request stage, data port wins over fetch when both are valid
// holds one request; core inputs must stay stable while valid and not ready
module mem_req_stage (
    input  logic                       clk,
    input  logic                       nrst,
    input  logic                       data_valid,
    output logic                       data_ready,
    input  mem_pkg::mem_op_e           data_op,
    input  logic [mem_pkg::ADDR_W-1:0] data_addr,
    input  logic [mem_pkg::DATA_W-1:0] data_wdata,
    input  logic                       fetch_valid,
    output logic                       fetch_ready,
    input  logic [mem_pkg::ADDR_W-1:0] fetch_addr,
    output logic                       req_valid,
    input  logic                       req_ready,
    output mem_pkg::req_src_e          req_src,
    output logic                       req_write,
    output mem_pkg::mem_op_e           req_op,
    output logic [mem_pkg::ADDR_W-1:0] req_addr,
    output logic [3:0]                 req_wstrb,
    output logic [mem_pkg::DATA_W-1:0] req_wdata,
    output logic                       req_misaligned
);
    import mem_pkg::*;

    logic              take_data;
    logic              take_fetch;
    logic              write_in;
    logic              misal_in;
    mem_op_e           op_in;
    logic [ADDR_W-1:0] addr_in;
    logic [3:0]        strb_in;

    assign data_ready  = !req_valid;
    assign fetch_ready = !req_valid && !data_valid;    // data goes first
    assign take_data   = data_valid && data_ready;
    assign take_fetch  = fetch_valid && fetch_ready;

    assign op_in    = take_data ? data_op : op_lw;     // fetch is a plain lw
    assign addr_in  = take_data ? data_addr : fetch_addr;
    assign write_in = take_data && data_op[3];

    always_comb begin
        case (op_in[1:0])
            2'b00: begin
                misal_in = 1'b0;
                strb_in  = 4'b0001 << addr_in[1:0];
            end
            2'b01: begin
                misal_in = addr_in[0];                 // half needs even address
                strb_in  = 4'b0011 << addr_in[1:0];
            end
            default: begin
                misal_in = |addr_in[1:0];
                strb_in  = 4'b1111;
            end
        endcase
        if (!write_in) begin
            strb_in = 4'b0000;                         // loads touch no lanes
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            req_valid <= 1'b0;
        end else if (take_data || take_fetch) begin
            req_valid <= 1'b1;
        end else if (req_ready) begin
            req_valid <= 1'b0;                         // handed to the master
        end
    end

    always_ff @(posedge clk) begin
        if (take_data || take_fetch) begin
            req_src        <= take_data ? src_data : src_fetch;
            req_write      <= write_in;
            req_op         <= op_in;
            req_addr       <= addr_in;
            req_wstrb      <= strb_in;
            req_wdata      <= data_wdata << {addr_in[1:0], 3'b000};  // move into lane
            req_misaligned <= misal_in;
        end
    end

    // a registered request must survive until the master takes it
    assert property (@(posedge clk) disable iff (!nrst)
        req_valid && !req_ready |=> req_valid && $stable(req_addr))
        else $error("request changed before master accepted it");

endmodule

// ==== hw/mem_sys_top.sv ====
`timescale 1ns/10ps
// memory access unit with its on-chip RAM
// one request held in the request stage, one on the bus
module mem_sys_top (
    input  logic                       clk,
    input  logic                       nrst,
    input  logic                       data_valid,
    output logic                       data_ready,
    input  mem_pkg::mem_op_e           data_op,
    input  logic [mem_pkg::ADDR_W-1:0] data_addr,
    input  logic [mem_pkg::DATA_W-1:0] data_wdata,
    input  logic                       fetch_valid,
    output logic                       fetch_ready,
    input  logic [mem_pkg::ADDR_W-1:0] fetch_addr,
    output logic                       load_valid,
    output logic [mem_pkg::DATA_W-1:0] load_data,
    output logic                       store_done,
    output logic                       inst_valid,
    output logic [mem_pkg::DATA_W-1:0] inst_data,
    output logic                       mem_err
);
    import mem_pkg::*;

    logic              req_valid, req_ready, req_write, req_misaligned;
    req_src_e          req_src;
    mem_op_e           req_op;
    logic [ADDR_W-1:0] req_addr;
    logic [3:0]        req_wstrb;
    logic [DATA_W-1:0] req_wdata;

    logic              rsp_valid, rsp_err;
    req_src_e          rsp_src;
    mem_op_e           rsp_op;
    logic [1:0]        rsp_addr_lo;
    logic [DATA_W-1:0] rsp_rdata;

    logic [ADDR_W-1:0] m_awaddr, m_araddr;
    logic              m_awvalid, m_awready, m_wvalid, m_wready;
    logic [DATA_W-1:0] m_wdata, m_rdata;
    logic [3:0]        m_wstrb;
    logic [1:0]        m_bresp, m_rresp;
    logic              m_bvalid, m_bready, m_arvalid, m_arready, m_rvalid, m_rready;

    mem_req_stage u_req (
        .clk(clk), .nrst(nrst),
        .data_valid(data_valid), .data_ready(data_ready), .data_op(data_op),
        .data_addr(data_addr), .data_wdata(data_wdata),
        .fetch_valid(fetch_valid), .fetch_ready(fetch_ready), .fetch_addr(fetch_addr),
        .req_valid(req_valid), .req_ready(req_ready), .req_src(req_src),
        .req_write(req_write), .req_op(req_op), .req_addr(req_addr),
        .req_wstrb(req_wstrb), .req_wdata(req_wdata), .req_misaligned(req_misaligned)
    );

    axi_lite_master u_master (
        .clk(clk), .nrst(nrst),
        .req_valid(req_valid), .req_ready(req_ready), .req_src(req_src),
        .req_write(req_write), .req_op(req_op), .req_addr(req_addr),
        .req_wstrb(req_wstrb), .req_wdata(req_wdata), .req_misaligned(req_misaligned),
        .rsp_valid(rsp_valid), .rsp_src(rsp_src), .rsp_op(rsp_op),
        .rsp_addr_lo(rsp_addr_lo), .rsp_rdata(rsp_rdata), .rsp_err(rsp_err),
        .awaddr(m_awaddr), .awvalid(m_awvalid), .awready(m_awready),
        .wdata(m_wdata), .wstrb(m_wstrb), .wvalid(m_wvalid), .wready(m_wready),
        .bresp(m_bresp), .bvalid(m_bvalid), .bready(m_bready),
        .araddr(m_araddr), .arvalid(m_arvalid), .arready(m_arready),
        .rdata(m_rdata), .rresp(m_rresp), .rvalid(m_rvalid), .rready(m_rready)
    );

    load_format_stage u_fmt (
        .clk(clk), .nrst(nrst),
        .rsp_valid(rsp_valid), .rsp_src(rsp_src), .rsp_op(rsp_op),
        .rsp_addr_lo(rsp_addr_lo), .rsp_rdata(rsp_rdata), .rsp_err(rsp_err),
        .load_valid(load_valid), .load_data(load_data), .store_done(store_done),
        .inst_valid(inst_valid), .inst_data(inst_data), .mem_err(mem_err)
    );

    axi_lite_ram u_ram (
        .clk(clk), .nrst(nrst),
        .awaddr(m_awaddr), .awvalid(m_awvalid), .awready(m_awready),
        .wdata(m_wdata), .wstrb(m_wstrb), .wvalid(m_wvalid), .wready(m_wready),
        .bresp(m_bresp), .bvalid(m_bvalid), .bready(m_bready),
        .araddr(m_araddr), .arvalid(m_arvalid), .arready(m_arready),
        .rdata(m_rdata), .rresp(m_rresp), .rvalid(m_rvalid), .rready(m_rready)
    );

endmodule

// ==== verif/mem_sys_checker.sv ====
`timescale 1ns/10ps
// response checker for mem_sys_top, keeps a byte model of the RAM
// responses are matched to requests strictly in acceptance order
// model bytes never written stay X and match an X read
module mem_sys_checker (
    input  logic                       clk,
    input  logic                       nrst,
    input  logic                       data_valid,
    input  logic                       data_ready,
    input  mem_pkg::mem_op_e           data_op,
    input  logic [mem_pkg::ADDR_W-1:0] data_addr,
    input  logic [mem_pkg::DATA_W-1:0] data_wdata,
    input  logic                       fetch_valid,
    input  logic                       fetch_ready,
    input  logic [mem_pkg::ADDR_W-1:0] fetch_addr,
    input  logic                       load_valid,
    input  logic [mem_pkg::DATA_W-1:0] load_data,
    input  logic                       store_done,
    input  logic                       inst_valid,
    input  logic [mem_pkg::DATA_W-1:0] inst_data,
    input  logic                       mem_err,
    output int                         err_cnt,
    output int                         rsp_cnt,
    output int                         pend_cnt
);
    import mem_pkg::*;

    logic [7:0]  model [RAM_BYTES];                    // little endian byte image
    req_src_e    src_q [$];                            // order of acceptance
    mem_op_e     op_q [$];
    logic [31:0] addr_q [$];
    logic [31:0] wd_q [$];
    logic [31:0] faddr_q [$];

    initial begin
        err_cnt  = 0;
        rsp_cnt  = 0;
        pend_cnt = 0;
    end

    // misaligned for its size, or outside the RAM
    function automatic logic is_fault(input mem_op_e op, input logic [31:0] addr);
        logic misal;
        case (op)
            op_lh, op_lhu, op_sh: misal = addr[0];
            op_lw, op_sw:         misal = |addr[1:0];
            default:              misal = 1'b0;
        endcase
        return misal || (addr >= RAM_BYTES);
    endfunction

    // expected load or fetch word, zero on a fault
    function automatic logic [31:0] ref_load(input mem_op_e op, input logic [31:0] addr);
        logic [10:0] a;
        logic [31:0] word;
        a = addr[10:0];
        if (is_fault(op, addr)) begin
            return 32'h0;
        end
        case (op)
            op_lb:   word = {{24{model[a][7]}}, model[a]};
            op_lbu:  word = {24'h0, model[a]};
            op_lh:   word = {{16{model[a+1][7]}}, model[a+1], model[a]};
            op_lhu:  word = {16'h0, model[a+1], model[a]};
            default: word = {model[a+3], model[a+2], model[a+1], model[a]};
        endcase
        return word;
    endfunction

    task automatic apply_store(input mem_op_e op, input logic [31:0] addr, input logic [31:0] wd);
        int n;
        n = (op == op_sb) ? 1 : (op == op_sh) ? 2 : 4;
        if (!is_fault(op, addr)) begin
            for (int i = 0; i < n; i++) begin
                model[addr[10:0] + i] = wd[8*i +: 8];  // low bytes of rs2
            end
        end
    endtask

    task automatic compare_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic compare_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[ERROR] %0t %s expected %b got %b", $time, name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_response();
        req_src_e    src;
        mem_op_e     op;
        logic [31:0] addr;
        logic [31:0] wd;
        logic        exp_err;
        rsp_cnt++;
        if ((load_valid && store_done) || (load_valid && inst_valid) || (store_done && inst_valid)) begin
            $display("%0t: more than one response pulse in the same cycle", $time);
            err_cnt++;
        end
        if (src_q.size() == 0) begin
            $display("%0t: response pulse with no request waiting for it", $time);
            err_cnt++;
        end else begin
            src = src_q.pop_front();
            if (src == src_data) begin
                op      = op_q.pop_front();
                addr    = addr_q.pop_front();
                wd      = wd_q.pop_front();
                exp_err = is_fault(op, addr);
                if (op[3] && !store_done) begin
                    $display("%0t: store to %h was not answered by store_done", $time, addr);
                    err_cnt++;
                end else if (!op[3] && !load_valid) begin
                    $display("%0t: load from %h was not answered by load_valid", $time, addr);
                    err_cnt++;
                end else if (!op[3]) begin
                    compare_word("load_data", ref_load(op, addr), load_data);
                end
                if (op[3]) begin
                    apply_store(op, addr, wd);
                end
            end else begin
                addr    = faddr_q.pop_front();
                exp_err = is_fault(op_lw, addr);
                if (!inst_valid) begin
                    $display("%0t: fetch from %h was answered out of order", $time, addr);
                    err_cnt++;
                end else begin
                    compare_word("inst_data", ref_load(op_lw, addr), inst_data);
                end
            end
            compare_bit("mem_err", exp_err, mem_err);
        end
    endtask

    // outputs straight out of reset
    initial begin
        @(posedge nrst);
        #1;
        compare_bit("data_ready", 1'b1, data_ready);
        compare_bit("fetch_ready", 1'b1, fetch_ready);
        compare_bit("load_valid", 1'b0, load_valid);
        compare_bit("store_done", 1'b0, store_done);
        compare_bit("inst_valid", 1'b0, inst_valid);
        compare_bit("mem_err", 1'b0, mem_err);
    end

    always @(posedge clk) begin
        if (nrst) begin
            if (load_valid || store_done || inst_valid) begin
                check_response();
            end else if (mem_err) begin
                $display("%0t: mem_err raised without a response pulse", $time);
                err_cnt++;
            end
            if (data_valid && data_ready) begin
                src_q.push_back(src_data);
                op_q.push_back(data_op);
                addr_q.push_back(data_addr);
                wd_q.push_back(data_wdata);
            end
            if (fetch_valid && fetch_ready) begin
                src_q.push_back(src_fetch);
                faddr_q.push_back(fetch_addr);
            end
            pend_cnt = src_q.size();
        end
    end

endmodule

// ==== verif/mem_sys_tb.sv ====
`timescale 1ns/10ps
// testbench for mem_sys_top, random traffic from a fixed seed
// loads and fetches stay in the first REGION_WORDS words, written first
module mem_sys_tb;
    import mem_pkg::*;

    localparam int CLK_NS       = 100;
    localparam int SEED         = 80897;
    localparam int REGION_WORDS = 64;
    localparam int N_DIRECTED   = 63;                  // sign, lane, fault and priority cases
    localparam int N_RAND       = 200;
    localparam int N_TXN        = REGION_WORDS + N_DIRECTED + 2 * N_RAND;
    localparam int WATCHDOG_NS  = (N_TXN * 20 + 3) * CLK_NS;

    logic        clk;
    logic        nrst;
    logic        data_valid;
    logic        data_ready;
    mem_op_e     data_op;
    logic [31:0] data_addr;
    logic [31:0] data_wdata;
    logic        fetch_valid;
    logic        fetch_ready;
    logic [31:0] fetch_addr;
    logic        load_valid;
    logic [31:0] load_data;
    logic        store_done;
    logic        inst_valid;
    logic [31:0] inst_data;
    logic        mem_err;
    int          err_cnt;
    int          rsp_cnt;
    int          pend_cnt;

    mem_op_e all_ops [8] = '{op_lb, op_lh, op_lw, op_lbu, op_lhu, op_sb, op_sh, op_sw};

    mem_sys_top uut (
        .clk(clk), .nrst(nrst),
        .data_valid(data_valid), .data_ready(data_ready), .data_op(data_op),
        .data_addr(data_addr), .data_wdata(data_wdata),
        .fetch_valid(fetch_valid), .fetch_ready(fetch_ready), .fetch_addr(fetch_addr),
        .load_valid(load_valid), .load_data(load_data), .store_done(store_done),
        .inst_valid(inst_valid), .inst_data(inst_data), .mem_err(mem_err)
    );

    mem_sys_checker u_chk (
        .clk(clk), .nrst(nrst),
        .data_valid(data_valid), .data_ready(data_ready), .data_op(data_op),
        .data_addr(data_addr), .data_wdata(data_wdata),
        .fetch_valid(fetch_valid), .fetch_ready(fetch_ready), .fetch_addr(fetch_addr),
        .load_valid(load_valid), .load_data(load_data), .store_done(store_done),
        .inst_valid(inst_valid), .inst_data(inst_data), .mem_err(mem_err),
        .err_cnt(err_cnt), .rsp_cnt(rsp_cnt), .pend_cnt(pend_cnt)
    );

    always #(CLK_NS / 2) clk = ~clk;

    task automatic data_request(input mem_op_e op, input logic [31:0] addr, input logic [31:0] wd);
        @(negedge clk);
        data_valid = 1'b1;
        data_op    = op;
        data_addr  = addr;
        data_wdata = wd;
        @(posedge clk);
        while (!data_ready) @(posedge clk);
        @(negedge clk);
        data_valid = 1'b0;
    endtask

    task automatic fetch_request(input logic [31:0] addr);
        @(negedge clk);
        fetch_valid = 1'b1;
        fetch_addr  = addr;
        @(posedge clk);
        while (!fetch_ready) @(posedge clk);
        @(negedge clk);
        fetch_valid = 1'b0;
    endtask

    // both ports raised in the same cycle, data must win
    task automatic paired_request(input mem_op_e op, input logic [31:0] addr,
                                  input logic [31:0] wd, input logic [31:0] faddr);
        @(negedge clk);
        data_valid  = 1'b1;
        data_op     = op;
        data_addr   = addr;
        data_wdata  = wd;
        fetch_valid = 1'b1;
        fetch_addr  = faddr;
        @(posedge clk);
        while (!data_ready) @(posedge clk);
        @(negedge clk);
        data_valid = 1'b0;
        @(posedge clk);
        while (!fetch_ready) @(posedge clk);
        @(negedge clk);
        fetch_valid = 1'b0;
    endtask

    function automatic logic [31:0] pick_fetch_addr();
        return 32'($urandom_range(REGION_WORDS - 1)) * 4;
    endfunction

    initial begin
        int          unused;
        mem_op_e     op;
        logic [31:0] addr;
        unused      = $urandom(SEED);
        clk         = 1'b0;
        nrst        = 1'b0;
        data_valid  = 1'b0;
        data_op     = op_lw;
        data_addr   = '0;
        data_wdata  = '0;
        fetch_valid = 1'b0;
        fetch_addr  = '0;
        repeat (3) @(negedge clk);
        nrst = 1'b1;
        @(negedge clk);

        for (int i = 0; i < REGION_WORDS; i++) begin
            data_request(op_sw, 32'(4 * i), $urandom);
        end

        // each store width and lane, read back as a word
        for (int off = 0; off < 4; off++) begin
            data_request(op_sb, 32'h40 + off, $urandom);
            data_request(op_lw, 32'h40, '0);
        end
        for (int off = 0; off < 4; off += 2) begin
            data_request(op_sh, 32'h48 + off, $urandom);
            data_request(op_lw, 32'h48, '0);
        end
        data_request(op_sw, 32'h50, $urandom);
        data_request(op_lw, 32'h50, '0);

        data_request(op_sw, 32'h60, 32'h80ff_a5c3);    // top bit set in every byte
        data_request(op_sw, 32'h64, 32'h7f01_5a3c);    // and clear in every byte
        for (int w = 0; w < 2; w++) begin
            for (int off = 0; off < 4; off++) begin
                data_request(op_lb, 32'h60 + 4 * w + off, '0);
                data_request(op_lbu, 32'h60 + 4 * w + off, '0);
            end
            for (int off = 0; off < 4; off += 2) begin
                data_request(op_lh, 32'h60 + 4 * w + off, '0);
                data_request(op_lhu, 32'h60 + 4 * w + off, '0);
            end
        end

        // misaligned, then confirm the word is untouched
        data_request(op_lh, 32'h61, '0);
        data_request(op_lhu, 32'h63, '0);
        data_request(op_lw, 32'h62, '0);
        data_request(op_lw, 32'h61, '0);
        data_request(op_sh, 32'h61, 32'hdead_beef);
        data_request(op_sw, 32'h62, 32'hdead_beef);
        data_request(op_sw, 32'h63, 32'hdead_beef);
        data_request(op_lw, 32'h60, '0);

        // outside the RAM, word 0 must not be aliased
        data_request(op_lw, 32'h800, '0);
        data_request(op_lb, 32'h801, '0);
        data_request(op_sw, 32'h800, 32'h1234_5678);
        data_request(op_sb, 32'hffff_fff0, 32'h0000_00aa);
        data_request(op_lw, 32'h1000, '0);
        fetch_request(32'h800);
        data_request(op_lw, 32'h0, '0);

        for (int i = 0; i < 4; i++) begin
            op = (i % 2 == 1) ? op_sw : op_lw;
            paired_request(op, pick_fetch_addr(), $urandom, pick_fetch_addr());
        end

        for (int n = 0; n < N_RAND; n++) begin
            op = all_ops[$urandom_range(7)];
            if ($urandom_range(15) == 0) begin
                addr = 32'h800 + $urandom_range(255);  // occasional bus error
            end else begin
                addr = $urandom_range(REGION_WORDS * 4 - 1);
            end
            case ($urandom_range(3))
                0:       fetch_request(pick_fetch_addr());
                1:       paired_request(op, addr, $urandom, pick_fetch_addr());
                default: data_request(op, addr, $urandom);
            endcase
        end

        while (pend_cnt != 0) @(negedge clk);
        repeat (8) @(negedge clk);                     // room for a stray pulse
        $display("responses checked: %0d, errors: %0d", rsp_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("run did not finish in %0d ns, %0d requests never answered, %0d errors",
                 WATCHDOG_NS, pend_cnt, err_cnt);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule
